//--- tb.f
conv_pkg.sv
conv_window_gen.sv
conv_kernel_seq.sv
conv_mac_3x3.sv
conv_unit_3x3.sv
tb_clk_gen.sv
tb_conv_assert.sv
tb_conv_unit.sv

//--- Makefile
TOP = tb_conv_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_conv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_unit
	import conv_pkg::*;
;

	localparam int qf = 10; // fraction bits dropped per product

	logic       clk;
	logic       rst_n;
	col_t       col_data;
	logic       col_last;
	logic       col_final;
	logic       col_valid;
	logic       col_ready;
	kern_t      kern_data;
	logic       kern_valid;
	logic       kern_ready;
	kern_mode_t mode;
	logic       pad_left;
	logic       pad_right;
	logic       kern_clear;
	res_t       res_data;
	logic       res_last;
	logic       res_valid;

	int          errors;
	int          seen;        // results taken by the monitor
	int          cols_driven;
	logic [31:0] rng;
	res_t        exp_res [$]; // expected results in order
	logic        exp_last [$];
	col_t        map_cols [$]; // all columns of the current map
	int          row_len [$];
	kern_t       map_kern [$]; // one kernel per row

	tb_clk_gen #(.period(8.0), .rst_cycles(16)) i_clk (.clk(clk), .rst_n(rst_n));

	conv_unit_3x3 #(.quant_frac(qf)) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.col_data   (col_data),
		.col_last   (col_last),
		.col_final  (col_final),
		.col_valid  (col_valid),
		.col_ready  (col_ready),
		.kern_data  (kern_data),
		.kern_valid (kern_valid),
		.kern_ready (kern_ready),
		.mode       (mode),
		.pad_left   (pad_left),
		.pad_right  (pad_right),
		.kern_clear (kern_clear),
		.res_data   (res_data),
		.res_last   (res_last),
		.res_valid  (res_valid)
	);

	bind conv_kernel_seq tb_conv_assert i_kseq_assert (
		.clk        (clk),
		.rst_n      (rst_n),
		.kern_clear (kern_clear),
		.init_load  (init_load),
		.stage_swap (stage_swap),
		.roi_ready  (roi_ready)
	);

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic col_t rand_col();
		col_t c;
		c.row0 = pix_t'(next_rand());
		c.row1 = pix_t'(next_rand());
		c.row2 = pix_t'(next_rand());
		return c;
	endfunction

	function automatic kern_t rand_kern();
		kern_t k;
		k = 144'({next_rand(), next_rand(), next_rand(), next_rand(), next_rand()}); // 144 of 160 bits
		return k;
	endfunction

	// one product, quantized with an arithmetic shift
	function automatic int qprod(input pix_t p, input pix_t c);
		int pr;
		pr = int'(p) * int'(c);
		return pr >>> qf;
	endfunction

	// window of columns a (x1), b (x2), c (x3)
	function automatic int window_sum(input col_t a, input col_t b, input col_t c,
			input kern_t k);
		int s;
		s = qprod(a.row0, k.x1y1) + qprod(a.row1, k.x1y2) + qprod(a.row2, k.x1y3);
		s += qprod(b.row0, k.x2y1) + qprod(b.row1, k.x2y2) + qprod(b.row2, k.x2y3);
		s += qprod(c.row0, k.x3y1) + qprod(c.row1, k.x3y2) + qprod(c.row2, k.x3y3);
		return s;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// expected windows of one row, pad columns are zero
	task automatic queue_row(input int first, input int len, input bit lp, input bit rp,
			input kern_t k);
		col_t ext [$];
		if (lp)
			ext.push_back(col_t'('0));
		for (int i = 0; i < len; i++)
			ext.push_back(map_cols[first + i]);
		if (rp)
			ext.push_back(col_t'('0));
		for (int i = 0; i + 2 < ext.size(); i++)
		begin
			exp_res.push_back(window_sum(ext[i], ext[i+1], ext[i+2], k));
			exp_last.push_back(i + 3 == ext.size()); // last window ends the row
		end
	endtask

	task automatic send_col(input col_t c, input bit last, input bit fin, input int gap);
		bit hs;
		repeat (gap)
		begin
			@(posedge clk);
			#1;
		end
		cols_driven++;
		col_data  = c;
		col_last  = last;
		col_final = fin;
		col_valid = 1'b1;
		hs = 1'b0;
		while (!hs)
		begin
			@(negedge clk);
			hs = col_ready; // stable up to the next edge
			@(posedge clk);
			#1;
		end
		col_valid = 1'b0;
	endtask

	task automatic send_kern(input kern_t k, input int gap);
		bit hs;
		repeat (gap)
		begin
			@(posedge clk);
			#1;
		end
		kern_data  = k;
		kern_valid = 1'b1;
		hs = 1'b0;
		while (!hs)
		begin
			@(negedge clk);
			hs = kern_ready;
			@(posedge clk);
			#1;
		end
		kern_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_res.size() != 0)
			@(negedge clk);
		repeat (10) @(negedge clk); // room for extra results
		@(posedge clk);
		#1;
	endtask

	function automatic int rand_gap(input int gap_max);
		return (gap_max == 0) ? 0 : int'(next_rand() % (gap_max + 1));
	endfunction

	// clear, then feed map_cols/row_len/map_kern and check every result
	task automatic run_map(input kern_mode_t md, input bit lp, input bit rp,
			input int gap_max, input int late_idx, input int late_cycles);
		bit elp;
		bit erp;
		int base;
		int seen0;
		int n_exp;
		mode      = md;
		pad_left  = lp;
		pad_right = rp;
		elp = lp | (md == mode_1x1); // 1x1 forces both pads
		erp = rp | (md == mode_1x1);
		base = 0;
		n_exp = exp_res.size();
		for (int r = 0; r < row_len.size(); r++)
		begin
			queue_row(base, row_len[r], elp, erp, map_kern[r]);
			base += row_len[r];
		end
		n_exp = exp_res.size() - n_exp;
		seen0 = seen;
		kern_clear = 1'b1;
		@(posedge clk);
		#1;
		kern_clear = 1'b0;
		fork
			begin
				for (int i = 0; i < map_kern.size(); i++)
				begin
					if (i == late_idx)
						repeat (late_cycles) @(posedge clk); // row end must stall
					send_kern(map_kern[i], rand_gap(gap_max));
				end
			end
			begin
				int b;
				b = 0;
				for (int r = 0; r < row_len.size(); r++)
				begin
					for (int c = 0; c < row_len[r]; c++)
						send_col(map_cols[b + c], c == row_len[r] - 1,
							r == row_len.size() - 1, rand_gap(gap_max));
					b += row_len[r];
				end
			end
		join
		wait_drain();
		check(64'(seen - seen0), 64'(n_exp), "result count");
	endtask

	task automatic new_map();
		map_cols.delete();
		row_len.delete();
		map_kern.delete();
	endtask

	task automatic add_row(input int len);
		for (int i = 0; i < len; i++)
			map_cols.push_back(rand_col());
		row_len.push_back(len);
		map_kern.push_back(rand_kern());
	endtask

	task automatic test_no_pad();
		new_map();
		add_row(8);
		run_map(mode_3x3, 1'b0, 1'b0, 0, -1, 0); // 6 windows
	endtask

	task automatic test_padding();
		for (int p = 0; p < 4; p++)
		begin
			new_map();
			add_row(6);
			run_map(mode_3x3, p[0], p[1], 0, -1, 0);
		end
	endtask

	task automatic test_1x1();
		kern_t k;
		new_map();
		add_row(7);
		k = '0;
		k.x2y2 = pix_t'(next_rand()); // centre tap only
		map_kern[0] = k;
		run_map(mode_1x1, 1'b0, 1'b0, 1, -1, 0); // pads off but ignored
	endtask

	task automatic test_kern_switch();
		new_map();
		add_row(8);
		add_row(6);
		add_row(7);
		run_map(mode_3x3, 1'b1, 1'b0, 0, 2, 120); // third kernel late
	endtask

	task automatic test_clear();
		new_map();
		add_row(5);
		run_map(mode_3x3, 1'b0, 1'b1, 0, -1, 0);
		send_kern(rand_kern(), 0); // stale kernel left in the pending buffer
		new_map();
		add_row(6);
		run_map(mode_3x3, 1'b1, 1'b1, 0, -1, 0);
	endtask

	task automatic test_random();
		logic [31:0] pads;
		new_map();
		for (int r = 0; r < 4; r++)
			add_row(3 + int'(next_rand() % 8));
		pads = next_rand();
		run_map(mode_3x3, pads[0], pads[1], 3, -1, 0);
	endtask

	// result monitor
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (rst_n === 1'b1 && res_valid === 1'b1)
			begin
				seen++;
				if (exp_res.size() == 0)
				begin
					errors++;
					$display("error at %0t ns: result %0h with none expected", $time, res_data);
				end
				else
				begin
					check(64'(res_data), 64'(exp_res.pop_front()), "res_data");
					check(64'(res_last), 64'(exp_last.pop_front()), "res_last");
				end
			end
		end
	end

	// watchdog, limit grows with the columns driven
	initial
	begin
		int cyc;
		cyc = 0;
		forever
		begin
			@(posedge clk);
			cyc++;
			if (cyc > 200 * cols_driven + 2000)
			begin
				$display("timeout: the DUT stopped accepting input or results after %0d cycles",
					cyc);
				$display("sim failed");
				$finish;
			end
		end
	end

	initial
	begin
		errors      = 0;
		seen        = 0;
		cols_driven = 0;
		rng         = 32'd94227;
		col_data    = '0;
		col_last    = 1'b0;
		col_final   = 1'b0;
		col_valid   = 1'b0;
		kern_data   = '0;
		kern_valid  = 1'b0;
		mode        = mode_3x3;
		pad_left    = 1'b0;
		pad_right   = 1'b0;
		kern_clear  = 1'b0;
		@(posedge rst_n);
		@(posedge clk);
		#1;
		test_no_pad();
		test_padding();
		test_1x1();
		test_kern_switch();
		test_clear();
		test_random();
		$display("errors: %0d, results checked: %0d", errors, seen);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_conv_assert.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_assert (
	input wire       clk,
	input wire       rst_n,
	input wire       kern_clear,
	input wire       init_load,  // first kernel copied into the columns
	input wire [2:0] stage_swap,
	input wire       roi_ready
);

	logic kern_loaded; // column registers hold a first kernel

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			kern_loaded <= 1'b0;
		else if (kern_clear)
			kern_loaded <= 1'b0; // clear drops the active kernel
		else if (init_load)
			kern_loaded <= 1'b1;
	end

	// first and last column stage never swap together
	swap_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(stage_swap[0] && stage_swap[2]))
		else $error("stage 0 and stage 2 swap in the same cycle");

	// no windows before the initial kernel is active
	no_roi_before_init: assert property (@(posedge clk) disable iff (!rst_n)
		!kern_loaded |-> !roi_ready)
		else $error("roi_ready high while no kernel is loaded");

	// datapath valid pipe reaches the sequencer through stage_swap
	swap_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(stage_swap) && !$isunknown(roi_ready))
		else $error("unknown swap or ready after reset");

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
	parameter realtime period    = 8.0, // ns
	parameter int      rst_cycles = 16
)(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk   = 1'b0;
		rst_n = 1'b0; // held low from time zero
		repeat (rst_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1; // released just after an edge, like the other inputs
	end

	always #(period / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- conv_unit_3x3.sv
`timescale 1ns/10ps
`default_nettype none

module conv_unit_3x3
	import conv_pkg::*;
#(
	parameter int quant_frac = 10 // product fraction bits dropped
)(
	input  logic       clk,
	input  logic       rst_n,
	// feature columns
	input  col_t       col_data,
	input  logic       col_last,
	input  logic       col_final,
	input  logic       col_valid,
	output logic       col_ready,
	// kernels
	input  kern_t      kern_data,
	input  logic       kern_valid,
	output logic       kern_ready,
	// run-time settings
	input  kern_mode_t mode,
	input  logic       pad_left,
	input  logic       pad_right,
	input  logic       kern_clear,
	// results, valid only
	output res_t       res_data,
	output logic       res_last,
	output logic       res_valid
);

	roi_beat_t  roi;
	logic       roi_valid;
	logic       roi_ready;
	logic       roi_fire;        // window enters the pipe
	logic       kern_allow_last;
	logic [2:0] stage_swap;
	logic       load_pending;
	logic       init_load;

	assign roi_fire = roi_valid & roi_ready;

	conv_window_gen i_window (
		.clk             (clk),
		.rst_n           (rst_n),
		.mode            (mode),
		.pad_left        (pad_left),
		.pad_right       (pad_right),
		.col_data        (col_data),
		.col_last        (col_last),
		.col_final       (col_final),
		.col_valid       (col_valid),
		.col_ready       (col_ready),
		.kern_allow_last (kern_allow_last),
		.roi_ready       (roi_ready),
		.roi             (roi),
		.roi_valid       (roi_valid)
	);

	conv_kernel_seq i_kseq (
		.clk             (clk),
		.rst_n           (rst_n),
		.kern_clear      (kern_clear),
		.kern_valid      (kern_valid),
		.kern_ready      (kern_ready),
		.stage_swap      (stage_swap),
		.roi_ready       (roi_ready),
		.kern_allow_last (kern_allow_last),
		.load_pending    (load_pending),
		.init_load       (init_load)
	);

	conv_mac_3x3 #(
		.quant_frac (quant_frac)
	) i_mac (
		.clk          (clk),
		.rst_n        (rst_n),
		.roi          (roi),
		.roi_fire     (roi_fire),
		.kern_data    (kern_data),
		.load_pending (load_pending),
		.init_load    (init_load),
		.stage_swap   (stage_swap),
		.res_data     (res_data),
		.res_last     (res_last),
		.res_valid    (res_valid)
	);

endmodule

`default_nettype wire

//--- conv_mac_3x3.sv
`timescale 1ns/10ps
`default_nettype none

module conv_mac_3x3
	import conv_pkg::*;
#(
	parameter int quant_frac = 10 // fraction bits dropped from each product
)(
	input  logic       clk,
	input  logic       rst_n,
	input  roi_beat_t  roi,
	input  logic       roi_fire,     // window accepted this cycle
	input  kern_t      kern_data,
	input  logic       load_pending,
	input  logic       init_load,
	output logic [2:0] stage_swap,
	output res_t       res_data,
	output logic       res_last,
	output logic       res_valid
);

	kern_t      kern_pend;        // next kernel, waits for a row end
	col_t       pend_col [3];     // pending kernel split by column
	col_t       kern_col [3];     // active coefficients per column stage
	col_t       roi_col  [3];     // window split by column
	col_t       stg      [3];     // pixels each column stage works on
	col_t       col1_q;           // x2 column, one cycle late
	col_t       col2_q1;          // x3 column, first delay
	col_t       col2_q2;          // x3 column, two cycles late
	logic [5:0] vld_sr;           // valid along the pipe
	logic [5:0] last_sr;          // row_last along the pipe
	res_t       prod  [3][3];     // raw products [column][row]
	res_t       qprod [3][3];     // quantized products
	res_t       csum  [3];        // column sums
	res_t       csum0_d1;
	res_t       csum0_d2;
	res_t       csum1_d1;

	// pick one row of a column
	function automatic pix_t col_row(input col_t c, input int r);
		pix_t p;
		case (r)
			0:       p = c.row0;
			1:       p = c.row1;
			default: p = c.row2;
		endcase
		return p;
	endfunction

	always_comb
	begin
		roi_col[0]  = {roi.roi.x1y3, roi.roi.x1y2, roi.roi.x1y1};
		roi_col[1]  = {roi.roi.x2y3, roi.roi.x2y2, roi.roi.x2y1};
		roi_col[2]  = {roi.roi.x3y3, roi.roi.x3y2, roi.roi.x3y1};
		pend_col[0] = {kern_pend.x1y3, kern_pend.x1y2, kern_pend.x1y1};
		pend_col[1] = {kern_pend.x2y3, kern_pend.x2y2, kern_pend.x2y1};
		pend_col[2] = {kern_pend.x3y3, kern_pend.x3y2, kern_pend.x3y1};
		stg[0]      = roi_col[0]; // stage 0 works in the accept cycle
		stg[1]      = col1_q;
		stg[2]      = col2_q2;
	end

	// stage k sees a row-last window k cycles after acceptance
	assign stage_swap[0] = roi_fire & roi.row_last;
	assign stage_swap[1] = vld_sr[0] & last_sr[0];
	assign stage_swap[2] = vld_sr[1] & last_sr[1];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vld_sr  <= '0;
			last_sr <= '0;
		end
		else
		begin
			vld_sr  <= {vld_sr[4:0], roi_fire};
			last_sr <= {last_sr[4:0], roi_fire & roi.row_last};
		end
	end

	// column stagger of the window data
	always_ff @(posedge clk)
	begin
		col1_q  <= roi_col[1];
		col2_q1 <= roi_col[2];
		col2_q2 <= col2_q1;
	end

	// kernel registers
	always_ff @(posedge clk)
	begin
		if (load_pending)
			kern_pend <= kern_data;
		for (int k = 0; k < 3; k++)
		begin
			// a stage swaps right after its row-last window
			if (init_load | stage_swap[k])
				kern_col[k] <= pend_col[k];
		end
	end

	// multiply, quantize, column add
	always_ff @(posedge clk)
	begin
		for (int k = 0; k < 3; k++)
		begin
			for (int r = 0; r < 3; r++)
			begin
				prod[k][r]  <= res_t'(col_row(stg[k], r)) * res_t'(col_row(kern_col[k], r));
				qprod[k][r] <= prod[k][r] >>> quant_frac; // arithmetic, keeps sign
			end
			csum[k] <= qprod[k][0] + qprod[k][1] + qprod[k][2];
		end
	end

	// line up the column sums, then the final adder
	always_ff @(posedge clk)
	begin
		csum0_d1 <= csum[0];
		csum0_d2 <= csum0_d1;
		csum1_d1 <= csum[1];
		res_data <= csum0_d2 + csum1_d1 + csum[2];
	end

	assign res_valid = vld_sr[5]; // six cycles after acceptance
	assign res_last  = last_sr[5];

endmodule

`default_nettype wire

//--- conv_kernel_seq.sv
`timescale 1ns/10ps
`default_nettype none

module conv_kernel_seq (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       kern_clear,      // drop all kernels, wait for a new first one
	input  logic       kern_valid,
	output logic       kern_ready,
	input  logic [2:0] stage_swap,      // column stage k swaps its kernel
	output logic       roi_ready,
	output logic       kern_allow_last,
	output logic       load_pending,    // write the pending buffer
	output logic       init_load        // copy pending into every column
);

	logic wait_init; // no active kernel yet
	logic init_now;  // first kernel is copied this cycle
	logic pend_full; // pending buffer holds a kernel
	logic swap_busy; // stage 0 has swapped, stage 2 not yet

	// no windows until the first kernel is in the columns
	assign roi_ready = ~(wait_init | init_now);

	// buffer free when empty, during the initial wait, or as stage 2 takes it
	assign kern_ready = ~kern_clear & ~init_now
		& (~pend_full | wait_init | stage_swap[2]);

	assign load_pending = kern_valid & kern_ready;
	assign init_load    = init_now;

	// row end may pass only with a fresh kernel and no swap running
	assign kern_allow_last = pend_full & ~swap_busy;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wait_init <= 1'b1;
		else if (kern_clear)
			wait_init <= 1'b1;
		else if (wait_init & kern_valid)
			wait_init <= 1'b0; // first kernel taken
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			init_now <= 1'b0;
		else
			init_now <= wait_init & kern_valid & ~kern_clear; // one cycle pulse
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pend_full <= 1'b0;
		else if (kern_clear | init_now)
			pend_full <= 1'b0;       // initial kernel leaves the buffer
		else if (kern_ready)
			pend_full <= kern_valid; // refill or free after stage 2 swap
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			swap_busy <= 1'b0;
		else if (kern_clear)
			swap_busy <= 1'b0;
		else if (stage_swap[0] | stage_swap[2])
			swap_busy <= stage_swap[0]; // set at stage 0, clear at stage 2
	end

endmodule

`default_nettype wire

//--- conv_window_gen.sv
`timescale 1ns/10ps
`default_nettype none

module conv_window_gen
	import conv_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  kern_mode_t mode,
	input  logic       pad_left,
	input  logic       pad_right,
	input  col_t       col_data,
	input  logic       col_last,        // last column of a row
	input  logic       col_final,       // row belongs to the last map row
	input  logic       col_valid,
	output logic       col_ready,
	input  logic       kern_allow_last, // next kernel already buffered
	input  logic       roi_ready,
	output roi_beat_t  roi,
	output logic       roi_valid
);

	// bit numbers of the one-hot position
	localparam int p_first  = 0;
	localparam int p_second = 1;
	localparam int p_steady = 2;
	localparam int p_rpad   = 3;

	logic [3:0] pos;      // column position, one-hot
	logic       need_lp;  // left zero column wanted
	logic       need_rp;  // right zero column wanted
	logic       last_ok;  // current column may close the row
	logic       col_fire;
	logic       pos_step;
	col_t       cur;      // current column
	col_t       prev1;    // one column back
	col_t       prev2;    // two columns back

	// 1x1 rides on the 3x3 window with both pads on
	assign need_lp = (mode == mode_1x1) | pad_left;
	assign need_rp = (mode == mode_1x1) | pad_right;

	// row end is held until a next kernel is waiting, unless the map ends here
	assign last_ok = ~col_last | col_final | kern_allow_last;

	assign col_ready = pos[p_first]                            // first column, no window yet
		| (pos[p_second] & (~need_lp | roi_ready))
		| (pos[p_steady] & roi_ready & last_ok);
	assign col_fire = col_valid & col_ready;

	assign roi_valid = (pos[p_second] & col_valid & need_lp) // left padded window
		| (pos[p_steady] & col_valid & last_ok)
		| (pos[p_rpad] & need_rp);                         // right padded window

	// zero column on the right side
	assign cur = pos[p_rpad] ? col_t'('0) : col_data;

	always_comb
	begin
		roi.roi.x1y1 = prev2.row0;
		roi.roi.x2y1 = prev1.row0;
		roi.roi.x3y1 = cur.row0;
		roi.roi.x1y2 = prev2.row1;
		roi.roi.x2y2 = prev1.row1;
		roi.roi.x3y2 = cur.row1;
		roi.roi.x1y3 = prev2.row2;
		roi.roi.x2y3 = prev1.row2;
		roi.roi.x3y3 = cur.row2;
		// with a right pad the pad window ends the row
		roi.row_last = need_rp ? pos[p_rpad] : col_last;
	end

	// first and second column always step, steady leaves on the row end
	assign pos_step = (col_fire & (pos[p_first] | pos[p_second]
			| (pos[p_steady] & col_last)))
		| (pos[p_rpad] & (~need_rp | roi_ready));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pos <= 4'b0001;
		else if (pos_step)
			pos <= {pos[2:0], pos[3]}; // rotate, pad state wraps to first
	end

	// column history
	always_ff @(posedge clk)
	begin
		if (col_fire)
		begin
			prev1 <= cur;
			prev2 <= pos[p_first] ? col_t'('0) : prev1; // row start gives left zeros
		end
	end

endmodule

`default_nettype wire

//--- conv_pkg.sv
`default_nettype none

package conv_pkg;

	// pixel and coefficient width, fixed for the whole unit
	localparam int pix_w = 16;

	typedef logic signed [pix_w-1:0]   pix_t; // one pixel or one coefficient
	typedef logic signed [2*pix_w-1:0] res_t; // full width result

	// one feature column, row0 sits in the low bits
	typedef struct packed {
		pix_t row2;
		pix_t row1;
		pix_t row0;
	} col_t;

	// 3x3 region of interest, x is the column and y the row
	typedef struct packed {
		pix_t x3y3;
		pix_t x2y3;
		pix_t x1y3;
		pix_t x3y2;
		pix_t x2y2;
		pix_t x1y2;
		pix_t x3y1;
		pix_t x2y1;
		pix_t x1y1; // oldest column, top row
	} roi_t;

	// coefficients, laid out like roi_t
	typedef struct packed {
		pix_t x3y3;
		pix_t x2y3;
		pix_t x1y3;
		pix_t x3y2;
		pix_t x2y2;
		pix_t x1y2;
		pix_t x3y1;
		pix_t x2y1;
		pix_t x1y1;
	} kern_t;

	typedef enum logic {
		mode_1x1 = 1'b0, // centre tap only, both pads forced
		mode_3x3 = 1'b1
	} kern_mode_t;

	// window beat from the builder into the datapath
	typedef struct packed {
		roi_t roi;
		logic row_last; // last window of the row
	} roi_beat_t;

endpackage

`default_nettype wire
